// File: design/rv_pkg.sv
package rv_pkg;

    // Datapath and memory sizes
    localparam int xlen       = 32;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 16;
    localparam int imem_aw    = 6;
    localparam int dmem_aw    = 4;

    // Major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // Function-3 codes
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // ALU operations shared by decode and execute
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;
    localparam logic [3:0] alu_sll = 4'd6;
    localparam logic [3:0] alu_srl = 4'd7;

    // addi x0,x0,0
    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Store and branch layout with the immediate split around the register fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r;
        s_view_t s;
    } inst_u;

endpackage

// File: design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [xlen-1:0]    load_data,
    input  logic               run,
    input  logic               stall,
    input  logic               redirect,
    input  logic [xlen-1:0]    redirect_pc,
    output logic [xlen-1:0]    if_pc,
    output logic [xlen-1:0]    if_inst
);

    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] fetch_word;

    // One program word written per load strobe
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // Low two pc bits dropped for the word index
    assign fetch_word = imem[pc[imem_aw+1:2]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            if_pc   <= '0;
            if_inst <= nop_word;
        end else if (!run) begin
            // Bubbles and pc held at zero until run
            pc      <= '0;
            if_pc   <= '0;
            if_inst <= nop_word;
        end else if (redirect) begin
            pc      <= redirect_pc;
            if_inst <= nop_word;
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_pc   <= pc;
            if_inst <= fetch_word;
        end
    end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ns

module decode_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] if_pc,
    input  logic [xlen-1:0] if_inst,
    input  logic            redirect,
    input  logic            wb_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    output logic            stall,
    output logic [xlen-1:0] id_pc,
    output logic [xlen-1:0] id_rs1_val,
    output logic [xlen-1:0] id_rs2_val,
    output logic [xlen-1:0] id_imm,
    output logic [4:0]      id_rs1,
    output logic [4:0]      id_rs2,
    output logic [4:0]      id_rd,
    output logic [3:0]      id_alu_op,
    output logic            id_alu_src,
    output logic            id_mem_read,
    output logic            id_mem_write,
    output logic            id_reg_write,
    output logic            id_branch,
    output logic            id_branch_ne
);

    logic [xlen-1:0] regs [32];
    inst_u           raw;
    inst_u           word;
    logic            use_rs2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic [3:0]      alu_op;
    logic            alu_src;
    logic            mem_read;
    logic            mem_write;
    logic            reg_write;
    logic            branch;
    logic            branch_ne;

    function automatic logic [3:0] alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            f3_add:  alu_sel = sub ? alu_sub : alu_add;
            f3_sll:  alu_sel = alu_sll;
            f3_slt:  alu_sel = alu_slt;
            f3_xor:  alu_sel = alu_xor;
            f3_srl:  alu_sel = alu_srl;
            f3_or:   alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    endfunction

    assign raw = if_inst;

    // rs2 field is immediate bits for I-type and loads
    assign use_rs2 = (raw.r.opcode == op_reg) || (raw.r.opcode == op_store) ||
                     (raw.r.opcode == op_branch);

    // Load-use hazard against the instruction now in execute
    assign stall = id_mem_read && (id_rd != 5'd0) &&
                   ((id_rd == raw.r.rs1) || (use_rs2 && id_rd == raw.r.rs2));

    // Bubble decodes as a nop
    assign word = (stall || redirect) ? nop_word : if_inst;

    // Read ports with same-cycle writeback bypass
    assign rs1_val = (wb_we && wb_rd == raw.r.rs1) ? wb_data : regs[raw.r.rs1];
    assign rs2_val = (wb_we && wb_rd == raw.r.rs2) ? wb_data : regs[raw.r.rs2];

    always_comb begin
        alu_op    = alu_add;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        imm       = {{20{word.r.funct7[6]}}, word.r.funct7, word.r.rs2};
        case (word.r.opcode)
            op_reg: begin
                reg_write = 1'b1;
                alu_op    = alu_sel(word.r.funct3, word.r.funct7[5]);
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_sel(word.r.funct3, 1'b0);
            end
            op_load: begin
                mem_read  = (word.r.funct3 == f3_lw);
                reg_write = (word.r.funct3 == f3_lw);
                alu_src   = 1'b1;
            end
            op_store: begin
                mem_write = (word.s.funct3 == f3_sw);
                alu_src   = 1'b1;
                imm       = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            op_branch: begin
                branch    = (word.s.funct3 == f3_beq) || (word.s.funct3 == f3_bne);
                branch_ne = (word.s.funct3 == f3_bne);
                // B-type bits reshuffled from the store layout
                imm = {{20{word.s.imm_hi[6]}}, word.s.imm_lo[0], word.s.imm_hi[5:0],
                       word.s.imm_lo[4:1], 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_pc        <= '0;
            id_rs1_val   <= '0;
            id_rs2_val   <= '0;
            id_imm       <= '0;
            id_rs1       <= '0;
            id_rs2       <= '0;
            id_rd        <= '0;
            id_alu_op    <= alu_add;
            id_alu_src   <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
            id_branch    <= 1'b0;
            id_branch_ne <= 1'b0;
        end else begin
            id_pc        <= if_pc;
            id_rs1_val   <= rs1_val;
            id_rs2_val   <= rs2_val;
            id_imm       <= imm;
            id_rs1       <= word.r.rs1;
            id_rs2       <= word.r.rs2;
            id_rd        <= word.r.rd;
            id_alu_op    <= alu_op;
            id_alu_src   <= alu_src;
            id_mem_read  <= mem_read;
            id_mem_write <= mem_write;
            // x0 targets never count as writes downstream
            id_reg_write <= reg_write && (word.r.rd != 5'd0);
            id_branch    <= branch;
            id_branch_ne <= branch_ne;
        end
    end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ns

module execute_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] id_pc,
    input  logic [xlen-1:0] id_rs1_val,
    input  logic [xlen-1:0] id_rs2_val,
    input  logic [xlen-1:0] id_imm,
    input  logic [4:0]      id_rs1,
    input  logic [4:0]      id_rs2,
    input  logic [4:0]      id_rd,
    input  logic [3:0]      id_alu_op,
    input  logic            id_alu_src,
    input  logic            id_mem_read,
    input  logic            id_mem_write,
    input  logic            id_reg_write,
    input  logic            id_branch,
    input  logic            id_branch_ne,
    input  logic            wb_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    output logic [xlen-1:0] ex_result,
    output logic [xlen-1:0] ex_store_data,
    output logic [4:0]      ex_rd,
    output logic            ex_mem_read,
    output logic            ex_mem_write,
    output logic            ex_reg_write
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;

    // Memory stage checked last so it wins over writeback
    // reg_write is never set for x0, so x0 is never forwarded
    always_comb begin
        op_a = id_rs1_val;
        op_b = id_rs2_val;
        if (wb_we && wb_rd == id_rs1) begin
            op_a = wb_data;
        end
        if (wb_we && wb_rd == id_rs2) begin
            op_b = wb_data;
        end
        if (ex_reg_write && ex_rd == id_rs1) begin
            op_a = ex_result;
        end
        if (ex_reg_write && ex_rd == id_rs2) begin
            op_b = ex_result;
        end
    end

    assign alu_b = id_alu_src ? id_imm : op_b;

    always_comb begin
        case (id_alu_op)
            alu_sub: alu_y = op_a - alu_b;
            alu_and: alu_y = op_a & alu_b;
            alu_or:  alu_y = op_a | alu_b;
            alu_xor: alu_y = op_a ^ alu_b;
            alu_slt: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
            alu_sll: alu_y = op_a << alu_b[4:0];
            alu_srl: alu_y = op_a >> alu_b[4:0];
            default: alu_y = op_a + alu_b;
        endcase
    end

    // Predicted not taken, so a taken branch redirects
    assign redirect    = id_branch && ((op_a == op_b) != id_branch_ne);
    assign redirect_pc = id_pc + id_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_result     <= '0;
            ex_store_data <= '0;
            ex_rd         <= '0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_reg_write  <= 1'b0;
        end else begin
            ex_result     <= alu_y;
            ex_store_data <= op_b;
            ex_rd         <= id_rd;
            ex_mem_read   <= id_mem_read;
            ex_mem_write  <= id_mem_write;
            ex_reg_write  <= id_reg_write;
        end
    end

endmodule

// File: design/result_unit.sv
`timescale 1ns/1ns

module result_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] ex_store_data,
    input  logic [4:0]      ex_rd,
    input  logic            ex_mem_read,
    input  logic            ex_mem_write,
    input  logic            ex_reg_write,
    output logic            wb_we,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0]    dmem [dmem_depth];
    logic [dmem_aw-1:0] word_addr;
    logic [xlen-1:0]    load_word;

    // Byte address to word index
    assign word_addr = ex_result[dmem_aw+1:2];
    assign load_word = dmem[word_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_write) begin
            dmem[word_addr] <= ex_store_data;
        end
    end

    // Writeback select folded into the register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end else begin
            wb_we   <= ex_reg_write;
            wb_rd   <= ex_rd;
            wb_data <= ex_mem_read ? load_word : ex_result;
        end
    end

endmodule

// File: design/pipe_cpu.sv
`timescale 1ns/1ns

module pipe_cpu import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [xlen-1:0]    load_data,
    input  logic               run,
    output logic               retire_valid,
    output logic [4:0]         retire_rd,
    output logic [xlen-1:0]    retire_data
);

    // Fetch to decode
    logic [xlen-1:0] if_pc;
    logic [xlen-1:0] if_inst;
    logic            stall;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    // Decode/execute register
    logic [xlen-1:0] id_pc;
    logic [xlen-1:0] id_rs1_val;
    logic [xlen-1:0] id_rs2_val;
    logic [xlen-1:0] id_imm;
    logic [4:0]      id_rs1;
    logic [4:0]      id_rs2;
    logic [4:0]      id_rd;
    logic [3:0]      id_alu_op;
    logic            id_alu_src;
    logic            id_mem_read;
    logic            id_mem_write;
    logic            id_reg_write;
    logic            id_branch;
    logic            id_branch_ne;

    // Execute/memory register
    logic [xlen-1:0] ex_result;
    logic [xlen-1:0] ex_store_data;
    logic [4:0]      ex_rd;
    logic            ex_mem_read;
    logic            ex_mem_write;
    logic            ex_reg_write;

    // Writeback
    logic            wb_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_pc       (if_pc),
        .if_inst     (if_inst)
    );

    decode_unit u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .redirect     (redirect),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .id_pc        (id_pc),
        .id_rs1_val   (id_rs1_val),
        .id_rs2_val   (id_rs2_val),
        .id_imm       (id_imm),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_alu_op    (id_alu_op),
        .id_alu_src   (id_alu_src),
        .id_mem_read  (id_mem_read),
        .id_mem_write (id_mem_write),
        .id_reg_write (id_reg_write),
        .id_branch    (id_branch),
        .id_branch_ne (id_branch_ne)
    );

    execute_unit u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_pc         (id_pc),
        .id_rs1_val    (id_rs1_val),
        .id_rs2_val    (id_rs2_val),
        .id_imm        (id_imm),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_rd         (id_rd),
        .id_alu_op     (id_alu_op),
        .id_alu_src    (id_alu_src),
        .id_mem_read   (id_mem_read),
        .id_mem_write  (id_mem_write),
        .id_reg_write  (id_reg_write),
        .id_branch     (id_branch),
        .id_branch_ne  (id_branch_ne),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write)
    );

    result_unit u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    // Every register write is a retire event
    assign retire_valid = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// File: bench/pipe_cpu_asserts.sv
`timescale 1ns/1ns

module pipe_cpu_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       retire_valid,
    input logic [4:0] retire_rd,
    input logic       stall,
    input logic       redirect
);

    // x0 writes are dropped in decode
    retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) retire_valid |-> retire_rd != 5'd0
    ) else $error("Retire reported for register x0");

    // A load-use hazard costs exactly one bubble
    stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !stall
    ) else $error("Stall held for two consecutive cycles");

    // Flushed slots cannot raise a second redirect
    redirect_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) redirect |=> !redirect
    ) else $error("Redirect held for two consecutive cycles");

endmodule

// File: bench/tb_pipe_cpu.sv
`timescale 1ns/1ns

module tb_pipe_cpu import rv_pkg::*; ();

    logic               clk;
    logic               rst_n;
    logic               load_en;
    logic [imem_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               run;
    logic               retire_valid;
    logic [4:0]         retire_rd;
    logic [xlen-1:0]    retire_data;

    // Program count, program, retire count, then rd/data pairs
    logic [31:0] stim [128];
    int          prog_count;
    int          exp_count;
    int          next_idx  = 0;
    int          errors    = 0;
    int          missing   = 0;
    int          extra     = 0;
    int          seed;
    bit          finished  = 1'b0;
    bit          timed_out = 1'b0;

    pipe_cpu dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind pipe_cpu pipe_cpu_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .stall        (stall),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_program();
        for (int i = 0; i < prog_count; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = i[imem_aw-1:0];
            load_data = stim[i + 1];
        end
        @(posedge clk);
        #1 load_en = 1'b0;
    endtask

    task automatic check_retire(input logic [4:0] rd, input logic [xlen-1:0] data);
        logic [4:0]      exp_rd;
        logic [xlen-1:0] exp_data;
        int              base;
        assert (next_idx < exp_count) else begin
            extra++;
            $display("Unexpected retire of x%0d at %0t after the trace was complete",
                     rd, $time);
        end
        if (next_idx < exp_count) begin
            base     = prog_count + 2 + 2 * next_idx;
            exp_rd   = stim[base][4:0];
            exp_data = stim[base + 1];
            assert (rd == exp_rd && data == exp_data) else begin
                errors++;
                $display("error %0t: retire %0d expected x%0d = %h, got x%0d = %h",
                         $time, next_idx, exp_rd, exp_data, rd, data);
            end
            next_idx++;
        end
    endtask

    task automatic finish_run();
        missing = exp_count - next_idx;
        $display("Errors: %0d, missing retires: %0d, extra retires: %0d",
                 errors, missing, extra);
        if (errors == 0 && missing == 0 && extra == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Retire outputs are registered, so sample them mid-cycle
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            check_retire(retire_rd, retire_data);
        end
    end

    initial begin
        int gap;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run       = 1'b0;
        seed      = 38027;
        $readmemh("bench/program_stimulus.txt", stim);
        prog_count = stim[0];
        exp_count  = stim[prog_count + 1];
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        load_program();
        // Idle gap of 0 to 7 cycles before run
        gap = $random(seed) & 7;
        repeat (gap + 1) @(posedge clk);
        #1 run = 1'b1;
        wait (next_idx == exp_count);
        // Let the closing self loop spin to catch stray retires
        repeat (16) @(posedge clk);
        finished = 1'b1;
        finish_run();
    end

    // Watchdog sized from the program and trace lengths
    initial begin
        wait (run);
        repeat (prog_count + 4 * exp_count + 50) @(posedge clk);
        if (!finished) begin
            $display("Timeout: retires stopped arriving after %0d of %0d",
                     next_idx, exp_count);
            timed_out = 1'b1;
            finish_run();
        end
    end

endmodule

// File: bench/program_stimulus.txt
// Program count, program words, retire count, then one rd and data pair per line
// All values are hex
25
// Independent immediates into x1 to x4
00500093 ffd00113 00c06193 7ff04213
// Forwarding from the memory and writeback stages
002082b3 40128333 005363b3 00132433 008094b3
01c3d513 004545b3 0f05f613 00160613 00c606b3
// Write to x0 is dropped and x0 reads as zero
06300013 00100733
// Store and load back with load-use stalls
00d02423 00802783 00378813 0101a223 01002883 40f88933
// Not taken bne then taken beq over two
01291463 00e08663 00100993 00200a13 00700a93
// Not taken beq then taken bne over two
001a8463 001a9663 00300b13 00400b93 001a8c13
// Load feeding a taken beq and the closing self loop
00802c83 00dc8463 00900d13 00a00d13 00000063
17
01 00000005
02 fffffffd
03 0000000c
04 000007ff
05 00000002
06 fffffffd
07 ffffffff
08 00000001
09 0000000a
0a 0000000f
0b 000007f0
0c 000000f0
0c 000000f1
0d 000001e2
0e 00000005
0f 000001e2
10 000001e5
11 000001e5
12 00000003
15 00000007
18 00000008
19 000001e2
1a 0000000a

// File: tb.f
design/rv_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/result_unit.sv
design/pipe_cpu.sv
bench/pipe_cpu_asserts.sv
bench/tb_pipe_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pipe_cpu testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pipe_cpu \
    -f tb.f -o sim_pipe_cpu
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_pipe_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0
